/* logic/trace_defines.svh */
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

//////////////////////////////////////////////////////////////////////////////
// replay channel geometry
//////////////////////////////////////////////////////////////////////////////

// number of independent replay channels
`define TRACE_CHANNELS 4

// payload width of each replay channel, channel 0 first
`define TRACE_W0 8
`define TRACE_W1 16
`define TRACE_W2 8
`define TRACE_W3 16

// compacted data field holds every channel when all logb bits are set
`define TRACE_DATA_W 48

// per-channel replay queue
`define TRACE_QUEUE_DEPTH 4
// used entries at which a queue reports almost-full
// one record may still be in flight past the ingress check
`define TRACE_ALMFUL_LEVEL 2

//////////////////////////////////////////////////////////////////////////////
// host register map (word addresses)
//////////////////////////////////////////////////////////////////////////////

`define WB_ADDR_W 3

`define WB_REG_DATA_LO 0
`define WB_REG_DATA_HI 1
`define WB_REG_STATUS 2
`define WB_REG_LOGE_COUNT 3

`endif

/* logic/trace_format_pkg.sv */
`include "trace_defines.svh"

// types that describe one packed trace record and its unpacked pieces
package trace_format_pkg;

  // one bit per replay channel, used for both logb_valid and loge_valid
  typedef logic [`TRACE_CHANNELS-1:0] chan_mask_t;

  // compacted data field
  // only channels whose logb bit is set take up space, packed from bit 0
  // in channel order
  typedef logic [`TRACE_DATA_W-1:0] trace_data_t;

  // one channel word, right aligned
  // the 8 bit channels are zero extended into it
  typedef logic [15:0] chan_data_t;

  // loge events per channel, wraps at 256
  typedef logic [7:0] loge_count_t;

  // the two unpacker instances each own half of the channels
  typedef enum logic {
    // channels 0 and 1
    group_low,
    // channels 2 and 3, whose offsets start after whatever the low group used
    group_high
  } chan_group_e;

endpackage

/* logic/wb_bus_pkg.sv */
`include "trace_defines.svh"

// host bus decode and the ingress handshake FSM
package wb_bus_pkg;

  // register select, decoded from the word address
  typedef enum logic [`WB_ADDR_W-1:0] {
    reg_data_lo    = `WB_ADDR_W'(`WB_REG_DATA_LO),
    // writing this word commits the record
    reg_data_hi    = `WB_ADDR_W'(`WB_REG_DATA_HI),
    reg_status     = `WB_ADDR_W'(`WB_REG_STATUS),
    reg_loge_count = `WB_ADDR_W'(`WB_REG_LOGE_COUNT)
  } wb_reg_e;

  // ingress FSM states
  typedef enum logic [1:0] {
    st_idle,
    // ack is high for exactly this one cycle
    st_ack,
    // a commit is held here while the replay queues are almost full
    st_wait_room
  } ingress_state_e;

endpackage

/* logic/trace_ingress.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

// wishbone classic slave in front of the trace decoder
// the host writes the low word, then the high word which commits the record
module trace_ingress (
  input  logic                                                 clk,
  input  logic                                                 rstn,
  input  logic                                                 wb_cyc,
  input  logic                                                 wb_stb,
  input  logic                                                 wb_we,
  input  logic [`WB_ADDR_W-1:0]                                wb_adr,
  input  logic [31:0]                                          wb_dat_w,
  output logic [31:0]                                          wb_dat_r,
  output logic                                                 wb_ack,
  input  logic                                                 almful,
  input  trace_format_pkg::loge_count_t [`TRACE_CHANNELS-1:0] loge_count,
  output logic                                                 rec_valid,
  output trace_format_pkg::chan_mask_t                         rec_logb,
  output trace_format_pkg::chan_mask_t                         rec_loge,
  output trace_format_pkg::trace_data_t                        rec_data
);
  import trace_format_pkg::*;
  import wb_bus_pkg::*;

  ingress_state_e state;
  ingress_state_e state_nxt;
  wb_reg_e        reg_sel;
  logic           req;
  logic           commit;
  logic [31:0]    lo_word;

  assign reg_sel = wb_reg_e'(wb_adr);
  assign req     = wb_cyc && wb_stb;
  assign commit  = req && wb_we && (reg_sel == reg_data_hi);

  // the master holds its signals until ack, so the ack cycle still sees them
  assign wb_ack = (state == st_ack);

  //////////////////////////////////////////////////////////////////////////
  // handshake FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        // a commit only goes through when the queues have room
        if (commit && almful) begin
          state_nxt = st_wait_room;
        end else if (req) begin
          state_nxt = st_ack;
        end
      end
      st_wait_room: begin
        // the master may give up on the cycle, otherwise ack once room frees
        if (!req) begin
          state_nxt = st_idle;
        end else if (!almful) begin
          state_nxt = st_ack;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= st_idle;
      rec_valid <= 1'b0;
    end else begin
      state     <= state_nxt;
      // record goes out in the cycle right after the commit ack
      rec_valid <= wb_ack && commit;
    end
  end

  // low word and the assembled record carry no reset
  always_ff @(posedge clk) begin
    if (wb_ack && req && wb_we && (reg_sel == reg_data_lo)) begin
      lo_word <= wb_dat_w;
    end
    if (wb_ack && commit) begin
      rec_logb <= lo_word[3:0];
      rec_loge <= lo_word[7:4];
      // data bits 55..32 of the record sit in the low 24 bits of the high word
      rec_data <= {wb_dat_w[23:0], lo_word[31:8]};
    end
  end

  // read mux, sampled by the master while ack is high
  always_comb begin
    case (reg_sel)
      reg_data_lo:    wb_dat_r = lo_word;
      reg_status:     wb_dat_r = {31'b0, almful};
      // channel 0 count lands in the low byte
      reg_loge_count: wb_dat_r = loge_count;
      default:        wb_dat_r = 32'b0;
    endcase
  end

endmodule

/* logic/channel_unpack.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

// unpacks the two channels of one group out of the compacted data field
// and keeps a small queue per channel
module channel_unpack #(
  parameter trace_format_pkg::chan_group_e GROUP = trace_format_pkg::group_low
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          rec_valid,
  input  trace_format_pkg::chan_mask_t  rec_logb,
  input  trace_format_pkg::trace_data_t rec_data,
  input  logic [1:0]                    pop,
  output logic [1:0]                    head_valid,
  output trace_format_pkg::chan_data_t  head_data_a,
  output trace_format_pkg::chan_data_t  head_data_b,
  output logic                          almful
);
  import trace_format_pkg::*;

  // first channel of this group and the widths of its two channels
  localparam int CH_A  = (GROUP == group_low) ? 0 : 2;
  localparam int W_A   = (GROUP == group_low) ? `TRACE_W0 : `TRACE_W2;
  localparam int W_B   = (GROUP == group_low) ? `TRACE_W1 : `TRACE_W3;
  localparam int OFF_W = $clog2(`TRACE_DATA_W + 1);
  localparam int PTR_W = $clog2(`TRACE_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`TRACE_QUEUE_DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT   = CNT_W'(`TRACE_QUEUE_DEPTH);
  localparam logic [CNT_W-1:0] ALMFUL_CNT = CNT_W'(`TRACE_ALMFUL_LEVEL);

  logic [OFF_W-1:0] base_off;
  logic [OFF_W-1:0] off [2];
  logic [1:0]       push_q;
  chan_data_t       push_data [2];
  chan_data_t       head_data [2];
  logic [1:0]       lane_almful;

  //////////////////////////////////////////////////////////////////////////
  // offset of each channel inside the compacted field
  //////////////////////////////////////////////////////////////////////////

  // a channel starts after every lower numbered channel that has data
  // so the high group first skips whatever the low group used
  always_comb begin
    base_off = '0;
    if (GROUP == group_high) begin
      if (rec_logb[0]) begin
        base_off = base_off + OFF_W'(`TRACE_W0);
      end
      if (rec_logb[1]) begin
        base_off = base_off + OFF_W'(`TRACE_W1);
      end
    end
    off[0] = base_off;
    off[1] = base_off + (rec_logb[CH_A] ? OFF_W'(W_A) : '0);
  end

  for (genvar lane = 0; lane < 2; lane++) begin : g_lane
    localparam int W = (lane == 0) ? W_A : W_B;

    chan_data_t       ext;
    chan_data_t       mem [`TRACE_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // slice out this channel and zero extend to a full channel word
    always_comb begin
      ext = '0;
      ext[W-1:0] = rec_data[off[lane] +: W];
    end

    // one register stage between the record and the queue write
    always_ff @(posedge clk) begin
      if (!rstn) begin
        push_q[lane] <= 1'b0;
      end else begin
        push_q[lane] <= rec_valid && rec_logb[CH_A + lane];
      end
    end

    always_ff @(posedge clk) begin
      push_data[lane] <= ext;
    end

    // queue, a push into a full queue only lands when the head leaves
    assign do_pop  = pop[lane] && (count != '0);
    assign do_push = push_q[lane] && ((count != FULL_CNT) || do_pop);

    always_ff @(posedge clk) begin
      if (!rstn) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (do_push) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (do_pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        if (do_push && !do_pop) begin
          count <= count + 1'b1;
        end else if (do_pop && !do_push) begin
          count <= count - 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (do_push) begin
        mem[wr_ptr] <= push_data[lane];
      end
    end

    assign head_valid[lane]  = (count != '0);
    assign head_data[lane]   = mem[rd_ptr];
    assign lane_almful[lane] = (count >= ALMFUL_CNT);
  end

  assign head_data_a = head_data[0];
  assign head_data_b = head_data[1];

  // either channel filling up stops the whole ingress
  assign almful = |lane_almful;

endmodule

/* logic/replay_merge.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

// joins the two channel groups into four replay ports
// also folds the group back-pressure and keeps the loge event counts
module replay_merge (
  input  logic                                                 clk,
  input  logic                                                 rstn,
  input  logic                                                 rec_valid,
  input  trace_format_pkg::chan_mask_t                         rec_loge,
  input  logic [1:0]                                           lo_head_valid,
  input  trace_format_pkg::chan_data_t                         lo_head_data_a,
  input  trace_format_pkg::chan_data_t                         lo_head_data_b,
  input  logic                                                 lo_almful,
  input  logic [1:0]                                           hi_head_valid,
  input  trace_format_pkg::chan_data_t                         hi_head_data_a,
  input  trace_format_pkg::chan_data_t                         hi_head_data_b,
  input  logic                                                 hi_almful,
  input  logic [`TRACE_CHANNELS-1:0]                           replay_ready,
  output logic [1:0]                                           lo_pop,
  output logic [1:0]                                           hi_pop,
  output logic [`TRACE_CHANNELS-1:0]                           replay_valid,
  output trace_format_pkg::chan_data_t                         replay_data_0,
  output trace_format_pkg::chan_data_t                         replay_data_1,
  output trace_format_pkg::chan_data_t                         replay_data_2,
  output trace_format_pkg::chan_data_t                         replay_data_3,
  output logic                                                 almful,
  output trace_format_pkg::loge_count_t [`TRACE_CHANNELS-1:0] loge_count
);
  import trace_format_pkg::*;

  logic [`TRACE_CHANNELS-1:0] fire;

  //////////////////////////////////////////////////////////////////////////
  // replay ports
  //////////////////////////////////////////////////////////////////////////

  // low group feeds channels 0 and 1, high group channels 2 and 3
  // each port shows its queue head directly so a stalled channel
  // leaves the other three alone
  assign replay_valid  = {hi_head_valid, lo_head_valid};
  assign replay_data_0 = lo_head_data_a;
  assign replay_data_1 = lo_head_data_b;
  assign replay_data_2 = hi_head_data_a;
  assign replay_data_3 = hi_head_data_b;

  // an entry leaves its queue on the valid and ready handshake
  assign fire   = replay_valid & replay_ready;
  assign lo_pop = fire[1:0];
  assign hi_pop = fire[3:2];

  // any almost-full queue holds back the next commit
  assign almful = lo_almful || hi_almful;

  //////////////////////////////////////////////////////////////////////////
  // loge event counters
  //////////////////////////////////////////////////////////////////////////

  // loge is counted when the record is issued, even when the record
  // carries no logb data at all
  always_ff @(posedge clk) begin
    if (!rstn) begin
      loge_count <= '0;
    end else if (rec_valid) begin
      for (int n = 0; n < `TRACE_CHANNELS; n++) begin
        // the count simply wraps past 255
        if (rec_loge[n]) begin
          loge_count[n] <= loge_count[n] + 1'b1;
        end
      end
    end
  end

endmodule

/* logic/trace_decoder_top.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

// replay trace decoder
// host records come in over wishbone and leave on four replay ports
module trace_decoder_top (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`WB_ADDR_W-1:0]        wb_adr,
  input  logic [31:0]                  wb_dat_w,
  output logic [31:0]                  wb_dat_r,
  output logic                         wb_ack,
  output logic [`TRACE_CHANNELS-1:0]   replay_valid,
  input  logic [`TRACE_CHANNELS-1:0]   replay_ready,
  output trace_format_pkg::chan_data_t replay_data_0,
  output trace_format_pkg::chan_data_t replay_data_1,
  output trace_format_pkg::chan_data_t replay_data_2,
  output trace_format_pkg::chan_data_t replay_data_3
);
  import trace_format_pkg::*;

  // issued record, shared by both unpackers and the merge stage
  logic        rec_valid;
  chan_mask_t  rec_logb;
  chan_mask_t  rec_loge;
  trace_data_t rec_data;

  // back-pressure and counts on their way back to the host port
  logic                              almful;
  loge_count_t [`TRACE_CHANNELS-1:0] loge_count;

  // queue heads of the low and high groups
  logic [1:0] lo_head_valid;
  logic [1:0] hi_head_valid;
  logic [1:0] lo_pop;
  logic [1:0] hi_pop;
  chan_data_t lo_head_data_a;
  chan_data_t lo_head_data_b;
  chan_data_t hi_head_data_a;
  chan_data_t hi_head_data_b;
  logic       lo_almful;
  logic       hi_almful;

  trace_ingress i_trace_ingress (
    .clk        (clk),
    .rstn       (rstn),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .almful     (almful),
    .loge_count (loge_count),
    .rec_valid  (rec_valid),
    .rec_logb   (rec_logb),
    .rec_loge   (rec_loge),
    .rec_data   (rec_data)
  );

  // both groups look at the same record in the same cycle
  channel_unpack #(.GROUP(group_low)) i_channel_unpack_lo (
    .clk         (clk),
    .rstn        (rstn),
    .rec_valid   (rec_valid),
    .rec_logb    (rec_logb),
    .rec_data    (rec_data),
    .pop         (lo_pop),
    .head_valid  (lo_head_valid),
    .head_data_a (lo_head_data_a),
    .head_data_b (lo_head_data_b),
    .almful      (lo_almful)
  );

  channel_unpack #(.GROUP(group_high)) i_channel_unpack_hi (
    .clk         (clk),
    .rstn        (rstn),
    .rec_valid   (rec_valid),
    .rec_logb    (rec_logb),
    .rec_data    (rec_data),
    .pop         (hi_pop),
    .head_valid  (hi_head_valid),
    .head_data_a (hi_head_data_a),
    .head_data_b (hi_head_data_b),
    .almful      (hi_almful)
  );

  replay_merge i_replay_merge (
    .clk            (clk),
    .rstn           (rstn),
    .rec_valid      (rec_valid),
    .rec_loge       (rec_loge),
    .lo_head_valid  (lo_head_valid),
    .lo_head_data_a (lo_head_data_a),
    .lo_head_data_b (lo_head_data_b),
    .lo_almful      (lo_almful),
    .hi_head_valid  (hi_head_valid),
    .hi_head_data_a (hi_head_data_a),
    .hi_head_data_b (hi_head_data_b),
    .hi_almful      (hi_almful),
    .replay_ready   (replay_ready),
    .lo_pop         (lo_pop),
    .hi_pop         (hi_pop),
    .replay_valid   (replay_valid),
    .replay_data_0  (replay_data_0),
    .replay_data_1  (replay_data_1),
    .replay_data_2  (replay_data_2),
    .replay_data_3  (replay_data_3),
    .almful         (almful),
    .loge_count     (loge_count)
  );

endmodule

/* verification/trace_decoder_tb.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

// directed testbench for the replay trace decoder
// records go in over wishbone and come back out on the four replay ports,
// where a monitor compares every entry against a per-channel model queue
module trace_decoder_tb;
  import trace_format_pkg::*;

  localparam int CLK_PERIOD     = 8;
  localparam int ACK_TIMEOUT    = 64;
  localparam int DRAIN_TIMEOUT  = 200;
  localparam int SPARSE_RECORDS = 40;
  localparam int LOGE_RECORDS   = 280;
  // the full record, the sparse run, three back-pressure records and the loge run
  localparam int NUM_RECORDS     = 1 + SPARSE_RECORDS + 3 + LOGE_RECORDS;
  localparam int WATCHDOG_CYCLES = NUM_RECORDS * 40 + 500;

  localparam logic [`WB_ADDR_W-1:0] ADR_DATA_LO = `WB_ADDR_W'(`WB_REG_DATA_LO);
  localparam logic [`WB_ADDR_W-1:0] ADR_DATA_HI = `WB_ADDR_W'(`WB_REG_DATA_HI);
  localparam logic [`WB_ADDR_W-1:0] ADR_STATUS  = `WB_ADDR_W'(`WB_REG_STATUS);
  localparam logic [`WB_ADDR_W-1:0] ADR_LOGE    = `WB_ADDR_W'(`WB_REG_LOGE_COUNT);

  logic                       clk;
  logic                       rstn;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [`WB_ADDR_W-1:0]      wb_adr;
  logic [31:0]                wb_dat_w;
  logic [31:0]                wb_dat_r;
  logic                       wb_ack;
  logic [`TRACE_CHANNELS-1:0] replay_valid;
  logic [`TRACE_CHANNELS-1:0] replay_ready;
  chan_data_t                 replay_data [`TRACE_CHANNELS];

  // expected entries per channel, in the order they must leave the DUT
  chan_data_t  exp_q [`TRACE_CHANNELS][$];
  loge_count_t loge_exp [`TRACE_CHANNELS];
  // a channel that showed valid without ready must hold its word
  logic        stalled [`TRACE_CHANNELS];
  chan_data_t  held_data [`TRACE_CHANNELS];
  int          errors;
  int          checks;

  trace_decoder_top i_trace_decoder_top (
    .clk           (clk),
    .rstn          (rstn),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .replay_valid  (replay_valid),
    .replay_ready  (replay_ready),
    .replay_data_0 (replay_data[0]),
    .replay_data_1 (replay_data[1]),
    .replay_data_2 (replay_data[2]),
    .replay_data_3 (replay_data[3])
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report_unexpected(input int n, input chan_data_t data);
    errors++;
    $display("error: replay channel %0d delivered 0x%0h when no entry was expected at %0t",
             n, data, $time);
  endtask

  // payload width of a channel taken from the channel geometry
  function automatic int chan_width(input int n);
    case (n)
      0: return `TRACE_W0;
      1: return `TRACE_W1;
      2: return `TRACE_W2;
      default: return `TRACE_W3;
    endcase
  endfunction

  function automatic logic entries_pending(input chan_mask_t mask);
    for (int n = 0; n < `TRACE_CHANNELS; n++) begin
      if (mask[n] && exp_q[n].size() != 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // samples on the rising edge, before any register in the DUT moves
  always @(posedge clk) begin
    if (!rstn) begin
      for (int n = 0; n < `TRACE_CHANNELS; n++) begin
        stalled[n]   <= 1'b0;
        held_data[n] <= '0;
      end
    end else begin
      for (int n = 0; n < `TRACE_CHANNELS; n++) begin
        if (stalled[n]) begin
          check_value($sformatf("replay_valid[%0d]", n), 32'(replay_valid[n]), 32'd1);
          check_value($sformatf("replay_data_%0d", n), 32'(replay_data[n]),
                      32'(held_data[n]));
        end
        if (replay_valid[n] && replay_ready[n]) begin
          if (exp_q[n].size() == 0) begin
            report_unexpected(n, replay_data[n]);
          end else begin
            check_value($sformatf("replay_data_%0d", n), 32'(replay_data[n]),
                        32'(exp_q[n].pop_front()));
          end
        end
        stalled[n]   <= replay_valid[n] && !replay_ready[n];
        held_data[n] <= replay_data[n];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // wishbone master and record helpers
  ////////////////////////////////////////////////////////////////////////////

  // every task starts and ends 1 ns after a rising edge
  task automatic start_access(input logic we, input logic [`WB_ADDR_W-1:0] adr,
                              input logic [31:0] dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
  endtask

  task automatic finish_access(output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk);
    while (!wb_ack && waited < ACK_TIMEOUT) begin
      waited++;
      @(posedge clk);
    end
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      errors++;
      $display("error: access to address %0d got no ack within %0d cycles",
               wb_adr, ACK_TIMEOUT);
    end
    #1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_dat_w = '0;
  endtask

  task automatic wb_write(input logic [`WB_ADDR_W-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused_rdata;
    start_access(1'b1, adr, dat);
    finish_access(unused_rdata);
  endtask

  task automatic wb_read(input logic [`WB_ADDR_W-1:0] adr, output logic [31:0] rdata);
    start_access(1'b0, adr, 32'd0);
    finish_access(rdata);
  endtask

  // builds one record with random channel words and fills the model
  // the compacted field packs only logb channels, from bit 0 in channel order,
  // and the unused top of the field is left as random filler
  task automatic prepare_record(input chan_mask_t logb, input chan_mask_t loge,
                                output logic [31:0] lo_word, output logic [31:0] hi_word);
    chan_data_t  vals [`TRACE_CHANNELS];
    trace_data_t data;
    int          offset;
    data   = trace_data_t'({$urandom, $urandom});
    offset = 0;
    for (int n = 0; n < `TRACE_CHANNELS; n++) begin
      vals[n] = chan_data_t'($urandom & ((32'd1 << chan_width(n)) - 32'd1));
      if (logb[n]) begin
        for (int b = 0; b < chan_width(n); b++) begin
          data[offset + b] = vals[n][b];
        end
        offset = offset + chan_width(n);
        exp_q[n].push_back(vals[n]);
      end
      if (loge[n]) begin
        loge_exp[n] = loge_exp[n] + 8'd1;
      end
    end
    lo_word = {data[23:0], loge, logb};
    // the top byte of the high word is not part of the record
    hi_word = {8'($urandom), data[47:24]};
  endtask

  task automatic send_record(input chan_mask_t logb, input chan_mask_t loge);
    logic [31:0] lo_word;
    logic [31:0] hi_word;
    prepare_record(logb, loge, lo_word, hi_word);
    wb_write(ADR_DATA_LO, lo_word);
    wb_write(ADR_DATA_HI, hi_word);
  endtask

  // waits until the selected channels have delivered everything expected
  task automatic wait_drain(input chan_mask_t mask);
    int waited;
    waited = 0;
    while (entries_pending(mask) && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (entries_pending(mask)) begin
      errors++;
      $display("error: channels in mask 0x%0h still owe entries after %0d cycles",
               mask, DRAIN_TIMEOUT);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [31:0] rdata;
    check_value("replay_valid", 32'(replay_valid), 32'd0);
    wb_read(ADR_STATUS, rdata);
    check_value("reg_status", rdata, 32'd0);
    wb_read(ADR_LOGE, rdata);
    check_value("reg_loge_count", rdata, 32'd0);
  endtask

  // field 48'h9a8b_7c6d_5e4f with every channel present
  // offsets 0, 8, 24 and 32 give 4f, 6d5e, 7c and 9a8b
  task automatic test_full_record();
    exp_q[0].push_back(16'h004f);
    exp_q[1].push_back(16'h6d5e);
    exp_q[2].push_back(16'h007c);
    exp_q[3].push_back(16'h9a8b);
    wb_write(ADR_DATA_LO, 32'h6d5e_4f0f);
    wb_write(ADR_DATA_HI, 32'h009a_8b7c);
    wait_drain(4'hf);
  endtask

  task automatic test_sparse();
    for (int i = 0; i < SPARSE_RECORDS; i++) begin
      send_record(chan_mask_t'($urandom), chan_mask_t'($urandom));
    end
    wait_drain(4'hf);
  endtask

  task automatic test_backpressure();
    logic [31:0] lo_word;
    logic [31:0] hi_word;
    logic [31:0] rdata;
    replay_ready = 4'b1011;
    // channel 0 always carries data so its drain shows the record has landed
    for (int i = 0; i < 2; i++) begin
      send_record(chan_mask_t'($urandom) | 4'b0101, chan_mask_t'($urandom));
    end
    wait_drain(4'b1011);
    wb_read(ADR_STATUS, rdata);
    check_value("reg_status", rdata, 32'd1);
    // the third commit has to sit in the wait state while channel 2 is stuck
    prepare_record(4'b0111, chan_mask_t'($urandom), lo_word, hi_word);
    wb_write(ADR_DATA_LO, lo_word);
    start_access(1'b1, ADR_DATA_HI, hi_word);
    repeat (12) begin
      @(posedge clk);
      check_value("wb_ack", 32'(wb_ack), 32'd0);
    end
    #1;
    replay_ready = 4'b1111;
    finish_access(rdata);
    wait_drain(4'hf);
    wb_read(ADR_STATUS, rdata);
    check_value("reg_status", rdata, 32'd0);
  endtask

  // channel 0 sees a loge bit on every record so its count wraps past 255
  task automatic test_loge_count();
    logic [31:0] rdata;
    chan_mask_t  logb;
    for (int i = 0; i < LOGE_RECORDS; i++) begin
      logb = (i % 8 == 0) ? 4'b0000 : chan_mask_t'($urandom);
      send_record(logb, chan_mask_t'($urandom) | 4'b0001);
    end
    wait_drain(4'hf);
    wb_read(ADR_LOGE, rdata);
    check_value("reg_loge_count", rdata, {loge_exp[3], loge_exp[2], loge_exp[1], loge_exp[0]});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(33));
    clk          = 1'b0;
    rstn         = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    replay_ready = 4'hf;
    errors       = 0;
    checks       = 0;
    for (int n = 0; n < `TRACE_CHANNELS; n++) begin
      loge_exp[n] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;

    test_reset_state();
    test_full_record();
    test_sparse();
    test_backpressure();
    test_loge_count();

    // nothing may come out once every model queue is empty
    wait_drain(4'hf);
    @(posedge clk);
    check_value("replay_valid", 32'(replay_valid), 32'd0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+logic
logic/trace_format_pkg.sv
logic/wb_bus_pkg.sv
logic/trace_ingress.sv
logic/channel_unpack.sv
logic/replay_merge.sv
logic/trace_decoder_top.sv
verification/trace_decoder_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := trace_decoder_tb
FILE_LIST  := list.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
